// File: Makefile
VERILATOR   ?= verilator
FILELIST    ?= wh_mem_top.f
TB_TOP      ?= wh_mem_tb
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?= -Wall
BUILD_FLAGS ?= --binary --timing --assert -j 0
SIM_ARGS    ?= +verilator+error+limit+100
FAIL_MSG    := *** TEST FAILED ***
PASS_MSG    := *** TEST PASSED ***
SIM_BIN     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not finish, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/wh_concentrator.sv
// merges NUM_IN request links into one wormhole stream, round robin per packet
// request header cid is overwritten with the granted input index
// responses are steered by header cid and held until len flits have passed
// grants open only once the first cycle after reset has gone by

`timescale 1ns/10ps
`default_nettype none

module wh_concentrator (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic [wh_mem_pkg::NUM_IN-1:0]               req_v_i,
  input  wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0]  req_flit_i,
  output logic [wh_mem_pkg::NUM_IN-1:0]               req_ready_o,
  output logic                                        cat_v_o,
  output wh_mem_pkg::flit_t                           cat_flit_o,
  input  logic                                        cat_ready_i,
  input  logic                                        ret_v_i,
  input  wh_mem_pkg::flit_t                           ret_flit_i,
  output logic                                        ret_ready_o,
  output logic [wh_mem_pkg::NUM_IN-1:0]               resp_v_o,
  output wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0]  resp_flit_o,
  input  logic [wh_mem_pkg::NUM_IN-1:0]               resp_ready_i
);

  logic                          en_q;

  logic                          req_open_q;
  logic [wh_mem_pkg::CID_W-1:0]  grant_q;
  logic [wh_mem_pkg::CID_W-1:0]  last_q;
  logic [wh_mem_pkg::LEN_W-1:0]  req_cnt_q;
  logic [wh_mem_pkg::CID_W-1:0]  pick;
  logic                          pick_v;
  logic [wh_mem_pkg::CID_W-1:0]  req_sel;
  logic                          req_fire;
  wh_mem_pkg::wh_hdr_t           req_hdr;

  logic                          ret_open_q;
  logic [wh_mem_pkg::CID_W-1:0]  route_q;
  logic [wh_mem_pkg::LEN_W-1:0]  ret_cnt_q;
  logic [wh_mem_pkg::CID_W-1:0]  route;
  logic                          ret_fire;
  wh_mem_pkg::wh_hdr_t           ret_hdr;

  // search starts one past the last winner
  always_comb begin : rr_pick
    logic [wh_mem_pkg::CID_W-1:0] idx;
    idx    = last_q;
    pick   = last_q;
    pick_v = 1'b0;
    for (int k = 0; k < wh_mem_pkg::NUM_IN; k++) begin
      idx = idx + 1'b1;
      if (!pick_v && req_v_i[idx]) begin
        pick   = idx;
        pick_v = 1'b1;
      end
    end
  end

  always_comb begin
    req_sel     = req_open_q ? grant_q : pick;
    req_hdr     = wh_mem_pkg::wh_hdr_t'(req_flit_i[pick]);
    req_hdr.cid = pick;
    cat_v_o     = req_open_q ? req_v_i[grant_q] : (en_q & pick_v);
    cat_flit_o  = req_open_q ? req_flit_i[grant_q] : wh_mem_pkg::flit_t'(req_hdr);
    req_ready_o = '0;
    req_ready_o[req_sel] = cat_ready_i & (req_open_q | (en_q & pick_v));
  end

  assign req_fire = cat_v_o & cat_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q       <= 1'b0;
      req_open_q <= 1'b0;
      grant_q    <= '0;
      last_q     <= '1;
      req_cnt_q  <= '0;
    end else begin
      en_q <= 1'b1;
      if (req_fire) begin
        if (!req_open_q) begin
          // header accepted, lock the link for its body
          last_q     <= pick;
          grant_q    <= pick;
          req_cnt_q  <= req_hdr.len;
          req_open_q <= (req_hdr.len != '0);
        end else begin
          req_cnt_q  <= req_cnt_q - 1'b1;
          req_open_q <= ((req_cnt_q - 1'b1) != '0);
        end
      end
    end
  end

  // return path
  always_comb begin
    ret_hdr     = wh_mem_pkg::wh_hdr_t'(ret_flit_i);
    route       = ret_open_q ? route_q : ret_hdr.cid;
    resp_v_o    = '0;
    resp_v_o[route] = ret_v_i;
    resp_flit_o = {wh_mem_pkg::NUM_IN{ret_flit_i}};
    ret_ready_o = resp_ready_i[route];
  end

  assign ret_fire = ret_v_i & ret_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ret_open_q <= 1'b0;
      route_q    <= '0;
      ret_cnt_q  <= '0;
    end else if (ret_fire) begin
      if (!ret_open_q) begin
        route_q    <= ret_hdr.cid;
        ret_cnt_q  <= ret_hdr.len;
        ret_open_q <= (ret_hdr.len != '0);
      end else begin
        ret_cnt_q  <= ret_cnt_q - 1'b1;
        ret_open_q <= ((ret_cnt_q - 1'b1) != '0);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/wh_flit_fifo.sv
// FIFO_DEPTH entry flit queue with ready/valid on both sides
// a written flit can leave on the next cycle, no same-cycle bypass
// in_ready_o depends only on occupancy

`timescale 1ns/10ps
`default_nettype none

module wh_flit_fifo (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              in_v_i,
  input  wh_mem_pkg::flit_t in_flit_i,
  output logic              in_ready_o,
  output logic              out_v_o,
  output wh_mem_pkg::flit_t out_flit_o,
  input  logic              out_ready_i
);

  wh_mem_pkg::flit_t                   mem [wh_mem_pkg::FIFO_DEPTH];
  logic [wh_mem_pkg::FIFO_PTR_W-1:0]   wr_ptr_q;
  logic [wh_mem_pkg::FIFO_PTR_W-1:0]   rd_ptr_q;
  logic [wh_mem_pkg::FIFO_CNT_W-1:0]   count_q;
  logic                                push;
  logic                                pop;

  function automatic logic [wh_mem_pkg::FIFO_PTR_W-1:0] next_ptr(
    input logic [wh_mem_pkg::FIFO_PTR_W-1:0] ptr
  );
    return (ptr == wh_mem_pkg::FIFO_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o = (count_q != wh_mem_pkg::FIFO_FULL);
  assign out_v_o    = (count_q != '0);
  assign out_flit_o = mem[rd_ptr_q];

  assign push = in_v_i & in_ready_o;
  assign pop  = out_v_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/wh_mem_pkg.sv
// shared widths, counts and types for the wormhole memory subsystem
// NUM_IN must equal 2**CID_W, the arbiter pointer wraps on its own width
// header fields sit in the low bits, reserved bits are zero in responses
// test memory holds MEM_WORDS words addressed by ADDR_W bits

`default_nettype none

package wh_mem_pkg;

  localparam int FLIT_W     = 32;
  localparam int NUM_IN     = 4;
  localparam int CID_W      = 2;
  localparam int LEN_W      = 4;
  localparam int ADDR_W     = 8;
  localparam int MEM_WORDS  = 256;
  localparam int FIFO_DEPTH = 4;

  localparam int HDR_RSVD_W = FLIT_W - CID_W - 2 - LEN_W;

  // flit buffer pointer and occupancy widths
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);
  localparam logic [FIFO_PTR_W-1:0] FIFO_LAST = FIFO_PTR_W'(FIFO_DEPTH - 1);

  typedef logic [FLIT_W-1:0] flit_t;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_READ_RESP,
    OP_WRITE_RESP
  } wh_op_e;

  // len counts the flits after the header
  typedef struct packed {
    logic [HDR_RSVD_W-1:0] rsvd;
    logic [CID_W-1:0]      cid;
    wh_op_e                op;
    logic [LEN_W-1:0]      len;
  } wh_hdr_t;

  typedef enum logic [2:0] {
    S_HDR,
    S_ADDR,
    S_DATA,
    S_RESP_HDR,
    S_RESP_DATA
  } mem_state_e;

endpackage

`default_nettype wire

// File: hw/wh_mem_top.sv
// wormhole memory subsystem: concentrator, flit buffer, test memory
// NUM_IN request links in, responses return on the link that sent the request
// senders need not set cid, it is assigned from the link index

`timescale 1ns/10ps
`default_nettype none

module wh_mem_top (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic [wh_mem_pkg::NUM_IN-1:0]               req_v_i,
  input  wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0]  req_flit_i,
  output logic [wh_mem_pkg::NUM_IN-1:0]               req_ready_o,
  output logic [wh_mem_pkg::NUM_IN-1:0]               resp_v_o,
  output wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0]  resp_flit_o,
  input  logic [wh_mem_pkg::NUM_IN-1:0]               resp_ready_i
);

  logic              cat_v;
  wh_mem_pkg::flit_t cat_flit;
  logic              cat_ready;
  logic              mem_v;
  wh_mem_pkg::flit_t mem_flit;
  logic              mem_ready;
  logic              ret_v;
  wh_mem_pkg::flit_t ret_flit;
  logic              ret_ready;

  wh_concentrator conc (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_v_i      (req_v_i),
    .req_flit_i   (req_flit_i),
    .req_ready_o  (req_ready_o),
    .cat_v_o      (cat_v),
    .cat_flit_o   (cat_flit),
    .cat_ready_i  (cat_ready),
    .ret_v_i      (ret_v),
    .ret_flit_i   (ret_flit),
    .ret_ready_o  (ret_ready),
    .resp_v_o     (resp_v_o),
    .resp_flit_o  (resp_flit_o),
    .resp_ready_i (resp_ready_i)
  );

  wh_flit_fifo fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_v_i      (cat_v),
    .in_flit_i   (cat_flit),
    .in_ready_o  (cat_ready),
    .out_v_o     (mem_v),
    .out_flit_o  (mem_flit),
    .out_ready_i (mem_ready)
  );

  wh_test_mem test_mem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_v_i      (mem_v),
    .req_flit_i   (mem_flit),
    .req_ready_o  (mem_ready),
    .resp_v_o     (ret_v),
    .resp_flit_o  (ret_flit),
    .resp_ready_i (ret_ready)
  );

endmodule

`default_nettype wire

// File: hw/wh_test_mem.sv
// simulation test memory behind one wormhole link
// any opcode other than OP_WRITE is served as a read
// unwritten words read back undefined, only low ADDR_W address bits are used
// one request at a time, the response must drain before the next header

`timescale 1ns/10ps
`default_nettype none

module wh_test_mem (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_v_i,
  input  wh_mem_pkg::flit_t req_flit_i,
  output logic              req_ready_o,
  output logic              resp_v_o,
  output wh_mem_pkg::flit_t resp_flit_o,
  input  logic              resp_ready_i
);

  wh_mem_pkg::flit_t              mem [wh_mem_pkg::MEM_WORDS];
  wh_mem_pkg::mem_state_e         state_q;
  wh_mem_pkg::mem_state_e         state_d;
  wh_mem_pkg::wh_op_e             op_q;
  logic [wh_mem_pkg::CID_W-1:0]   cid_q;
  logic [wh_mem_pkg::ADDR_W-1:0]  addr_q;
  wh_mem_pkg::flit_t              rdata_q;
  wh_mem_pkg::wh_hdr_t            req_hdr;
  wh_mem_pkg::wh_hdr_t            resp_hdr;
  logic                           is_wr;
  logic                           req_fire;
  logic                           resp_fire;

  assign req_hdr   = wh_mem_pkg::wh_hdr_t'(req_flit_i);
  assign is_wr     = (op_q == wh_mem_pkg::OP_WRITE);
  assign req_fire  = req_v_i & req_ready_o;
  assign resp_fire = resp_v_o & resp_ready_i;

  always_comb begin
    req_ready_o = (state_q == wh_mem_pkg::S_HDR) || (state_q == wh_mem_pkg::S_ADDR) ||
                  (state_q == wh_mem_pkg::S_DATA);
    resp_v_o    = (state_q == wh_mem_pkg::S_RESP_HDR) ||
                  (state_q == wh_mem_pkg::S_RESP_DATA);
  end

  // response header, reserved bits stay zero
  always_comb begin
    resp_hdr     = '0;
    resp_hdr.cid = cid_q;
    if (is_wr) begin
      resp_hdr.op  = wh_mem_pkg::OP_WRITE_RESP;
      resp_hdr.len = '0;
    end else begin
      resp_hdr.op  = wh_mem_pkg::OP_READ_RESP;
      resp_hdr.len = {{(wh_mem_pkg::LEN_W-1){1'b0}}, 1'b1};
    end
    resp_flit_o = (state_q == wh_mem_pkg::S_RESP_DATA) ? rdata_q
                                                       : wh_mem_pkg::flit_t'(resp_hdr);
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      wh_mem_pkg::S_HDR: begin
        if (req_fire) state_d = wh_mem_pkg::S_ADDR;
      end
      wh_mem_pkg::S_ADDR: begin
        if (req_fire) state_d = is_wr ? wh_mem_pkg::S_DATA : wh_mem_pkg::S_RESP_HDR;
      end
      wh_mem_pkg::S_DATA: begin
        if (req_fire) state_d = wh_mem_pkg::S_RESP_HDR;
      end
      wh_mem_pkg::S_RESP_HDR: begin
        if (resp_fire) state_d = is_wr ? wh_mem_pkg::S_HDR : wh_mem_pkg::S_RESP_DATA;
      end
      wh_mem_pkg::S_RESP_DATA: begin
        if (resp_fire) state_d = wh_mem_pkg::S_HDR;
      end
      default: state_d = wh_mem_pkg::S_HDR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= wh_mem_pkg::S_HDR;
    end else begin
      state_q <= state_d;
    end
  end

  // captured request fields and the word array
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      case (state_q)
        wh_mem_pkg::S_HDR: begin
          op_q  <= req_hdr.op;
          cid_q <= req_hdr.cid;
        end
        wh_mem_pkg::S_ADDR: begin
          addr_q  <= req_flit_i[wh_mem_pkg::ADDR_W-1:0];
          rdata_q <= mem[req_flit_i[wh_mem_pkg::ADDR_W-1:0]];
        end
        wh_mem_pkg::S_DATA: begin
          mem[addr_q] <= req_flit_i;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sim/wh_mem_checker.sv
// response link assertions, bound into every wh_mem_top instance
// data flits look like any word, so packet ends are tracked from header len
// err_cnt counts failed assertions for the testbench summary

`timescale 1ns/10ps
`default_nettype none

module wh_mem_checker (
  input logic                                       clk_i,
  input logic                                       rst_i,
  input logic [wh_mem_pkg::NUM_IN-1:0]              req_ready_o,
  input logic [wh_mem_pkg::NUM_IN-1:0]              resp_v_o,
  input wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0] resp_flit_o,
  input logic [wh_mem_pkg::NUM_IN-1:0]              resp_ready_i
);

  int                           err_cnt = 0;
  wh_mem_pkg::wh_hdr_t          hdr   [wh_mem_pkg::NUM_IN];
  logic [wh_mem_pkg::LEN_W-1:0] rem_q [wh_mem_pkg::NUM_IN];

  always_comb begin
    for (int i = 0; i < wh_mem_pkg::NUM_IN; i++) begin
      hdr[i] = wh_mem_pkg::wh_hdr_t'(resp_flit_o[i]);
    end
  end

  // flits still owed by the open response on each link
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < wh_mem_pkg::NUM_IN; i++) begin
      if (rst_i) begin
        rem_q[i] <= '0;
      end else if (resp_v_o[i] && resp_ready_i[i]) begin
        rem_q[i] <= (rem_q[i] == '0) ? hdr[i].len : rem_q[i] - 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    $past(rst_i) |-> (resp_v_o == '0 && req_ready_o == '0))
    else begin
      err_cnt++;
      $error("valid or ready high during reset or the cycle after");
    end

  for (genvar i = 0; i < wh_mem_pkg::NUM_IN; i++) begin : g_link
    localparam logic [wh_mem_pkg::NUM_IN-1:0] OWN = 1 << i;

    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (resp_v_o[i] && !resp_ready_i[i]) |=> (resp_v_o[i] && $stable(resp_flit_o[i])))
      else begin
        err_cnt++;
        $error("link %0d response changed while stalled", i);
      end

    a_body_owned: assert property (@(posedge clk_i) disable iff (rst_i)
      (rem_q[i] != '0) |-> ((resp_v_o & ~OWN) == '0))
      else begin
        err_cnt++;
        $error("another link got a flit inside the response on link %0d", i);
      end

    a_hdr_shape: assert property (@(posedge clk_i) disable iff (rst_i)
      (resp_v_o[i] && rem_q[i] == '0) |->
        (hdr[i].rsvd == '0 && hdr[i].cid == i &&
         ((hdr[i].op == wh_mem_pkg::OP_READ_RESP && hdr[i].len == 1) ||
          (hdr[i].op == wh_mem_pkg::OP_WRITE_RESP && hdr[i].len == 0))))
      else begin
        err_cnt++;
        $error("bad response header on link %0d", i);
      end
  end

endmodule

bind wh_mem_top wh_mem_checker chk (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_ready_o  (req_ready_o),
  .resp_v_o     (resp_v_o),
  .resp_flit_o  (resp_flit_o),
  .resp_ready_i (resp_ready_i)
);

`default_nettype wire

// File: sim/wh_mem_tb.sv
// testbench for wh_mem_top with all four request links active
// link n only touches addresses whose low two bits equal n,
// so the scoreboard does not depend on arbitration order
// checker failures are read from the bound instance chk

`timescale 1ns/10ps
`default_nettype none

module wh_mem_tb;

  localparam int TIMEOUT      = 400;
  localparam int OPS_PER_LINK = 16;

  logic                                       clk_i;
  logic                                       rst_i;
  logic [wh_mem_pkg::NUM_IN-1:0]              req_v_i;
  wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0] req_flit_i;
  logic [wh_mem_pkg::NUM_IN-1:0]              req_ready_o;
  logic [wh_mem_pkg::NUM_IN-1:0]              resp_v_o;
  wh_mem_pkg::flit_t [wh_mem_pkg::NUM_IN-1:0] resp_flit_o;
  logic [wh_mem_pkg::NUM_IN-1:0]              resp_ready_i = '0;

  int                value_errs   = 0;
  int                timeout_errs = 0;
  // 0 always ready, 1 random stalls, 2 all blocked
  int                ready_mode;
  wh_mem_pkg::flit_t sb_mem [wh_mem_pkg::MEM_WORDS];

  wh_mem_top DUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_v_i      (req_v_i),
    .req_flit_i   (req_flit_i),
    .req_ready_o  (req_ready_o),
    .resp_v_o     (resp_v_o),
    .resp_flit_o  (resp_flit_o),
    .resp_ready_i (resp_ready_i)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    for (int i = 0; i < wh_mem_pkg::NUM_IN; i++) begin
      case (ready_mode)
        0:       resp_ready_i[i] <= 1'b1;
        1:       resp_ready_i[i] <= (($urandom % 3) != 0);
        default: resp_ready_i[i] <= 1'b0;
      endcase
    end
  end

  function automatic void check_val(input string name, input wh_mem_pkg::flit_t exp,
                                    input wh_mem_pkg::flit_t got);
    assert (got === exp) else begin
      value_errs++;
      $display("[FAIL] %0t ns %s expected 0x%08h got 0x%08h", $time, name, exp, got);
    end
  endfunction

  function automatic wh_mem_pkg::flit_t req_hdr(input wh_mem_pkg::wh_op_e op, input int len);
    wh_mem_pkg::wh_hdr_t h;
    wh_mem_pkg::flit_t   rnd;
    rnd   = $urandom;
    h     = '0;
    h.op  = op;
    h.len = len[wh_mem_pkg::LEN_W-1:0];
    // sender cid is junk and gets replaced by the concentrator
    h.cid = rnd[wh_mem_pkg::CID_W-1:0];
    return h;
  endfunction

  function automatic void check_hdr(input int link, input wh_mem_pkg::flit_t got,
                                    input wh_mem_pkg::wh_op_e op);
    wh_mem_pkg::wh_hdr_t exp;
    exp     = '0;
    exp.op  = op;
    exp.cid = link[wh_mem_pkg::CID_W-1:0];
    // read responses carry one data flit and write responses none
    exp.len = {{(wh_mem_pkg::LEN_W-1){1'b0}}, op == wh_mem_pkg::OP_READ_RESP};
    check_val($sformatf("resp_flit_o[%0d]", link), exp, got);
  endfunction

  function automatic logic [wh_mem_pkg::ADDR_W-1:0] pick_addr(input int link);
    int a;
    a = ($urandom % (wh_mem_pkg::MEM_WORDS / wh_mem_pkg::NUM_IN)) * wh_mem_pkg::NUM_IN + link;
    return a[wh_mem_pkg::ADDR_W-1:0];
  endfunction

  // upper bits are junk since the memory uses only the low ADDR_W bits
  function automatic wh_mem_pkg::flit_t addr_flit(input logic [wh_mem_pkg::ADDR_W-1:0] addr);
    wh_mem_pkg::flit_t f;
    f = $urandom;
    f[wh_mem_pkg::ADDR_W-1:0] = addr;
    return f;
  endfunction

  task automatic send_flit(input int link, input wh_mem_pkg::flit_t flit, inout bit ok);
    int waited;
    bit stuck;
    waited = 0;
    if (!ok) return;
    req_v_i[link]    <= 1'b1;
    req_flit_i[link] <= flit;
    @(negedge clk_i);
    while (!req_ready_o[link] && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    stuck = !req_ready_o[link];
    @(posedge clk_i);
    req_v_i[link] <= 1'b0;
    if (stuck) begin
      timeout_errs++;
      ok = 0;
      $display("timeout: link %0d request flit was never accepted", link);
    end
  endtask

  task automatic recv_flit(input int link, output wh_mem_pkg::flit_t flit, inout bit ok);
    int waited;
    waited = 0;
    flit   = '0;
    if (!ok) return;
    @(negedge clk_i);
    while (!(resp_v_o[link] && resp_ready_i[link]) && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(resp_v_o[link] && resp_ready_i[link])) begin
      timeout_errs++;
      ok = 0;
      $display("timeout: link %0d got no response flit", link);
    end else begin
      flit = resp_flit_o[link];
      @(posedge clk_i);
    end
  endtask

  task automatic do_write(input int link, input logic [wh_mem_pkg::ADDR_W-1:0] addr,
                          input wh_mem_pkg::flit_t data, inout bit ok);
    wh_mem_pkg::flit_t resp;
    send_flit(link, req_hdr(wh_mem_pkg::OP_WRITE, 2), ok);
    send_flit(link, addr_flit(addr), ok);
    send_flit(link, data, ok);
    if (ok) begin
      sb_mem[addr] = data;
    end
    recv_flit(link, resp, ok);
    if (ok) begin
      check_hdr(link, resp, wh_mem_pkg::OP_WRITE_RESP);
    end
  endtask

  task automatic do_read(input int link, input logic [wh_mem_pkg::ADDR_W-1:0] addr,
                         inout bit ok);
    wh_mem_pkg::flit_t resp;
    send_flit(link, req_hdr(wh_mem_pkg::OP_READ, 1), ok);
    send_flit(link, addr_flit(addr), ok);
    recv_flit(link, resp, ok);
    if (ok) begin
      check_hdr(link, resp, wh_mem_pkg::OP_READ_RESP);
    end
    recv_flit(link, resp, ok);
    if (ok) begin
      check_val($sformatf("resp_flit_o[%0d]", link), sb_mem[addr], resp);
    end
  endtask

  task automatic run_link(input int link, input int n_ops);
    logic [wh_mem_pkg::ADDR_W-1:0] written [$];
    logic [wh_mem_pkg::ADDR_W-1:0] addr;
    bit                            ok;
    ok = 1;
    for (int k = 0; k < n_ops && ok; k++) begin
      if (written.size() == 0 || ($urandom % 2) == 0) begin
        addr = pick_addr(link);
        do_write(link, addr, $urandom, ok);
        written.push_back(addr);
      end else begin
        addr = written[$urandom % written.size()];
        do_read(link, addr, ok);
      end
    end
  endtask

  initial begin : main
    logic [wh_mem_pkg::ADDR_W-1:0] addr;
    bit                            ok;
    int                            chk_errs;
    void'($urandom(32'h3264d74e));
    rst_i      <= 1'b1;
    req_v_i    <= '0;
    req_flit_i <= '0;
    ready_mode <= 0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    // one write then read on each link without stalls
    ok = 1;
    for (int l = 0; l < wh_mem_pkg::NUM_IN; l++) begin
      addr = pick_addr(l);
      do_write(l, addr, $urandom, ok);
      do_read(l, addr, ok);
    end
    ready_mode <= 1;
    fork
      run_link(0, OPS_PER_LINK);
      run_link(1, OPS_PER_LINK);
      run_link(2, OPS_PER_LINK);
      run_link(3, OPS_PER_LINK);
    join
    // with every link blocked a stray response would stay visible
    ready_mode <= 2;
    repeat (20) @(negedge clk_i);
    check_val("resp_v_o", '0, wh_mem_pkg::flit_t'(resp_v_o));
    chk_errs = DUT.chk.err_cnt;
    $display("errors: %0d value, %0d timeout, %0d checker", value_errs, timeout_errs, chk_errs);
    if (value_errs + timeout_errs + chk_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wh_mem_top.f
hw/wh_mem_pkg.sv
hw/wh_concentrator.sv
hw/wh_flit_fifo.sv
hw/wh_test_mem.sv
hw/wh_mem_top.sv
sim/wh_mem_checker.sv
sim/wh_mem_tb.sv
